//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ecc_codec
FILELIST  ?= ecc_codec.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- ecc_asserts.sv
`default_nettype none
`timescale 1ns/1ns

module ecc_asserts (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              busy,
    input wire logic              done,
    input wire ecc_pkg::ecc_res_t res
);

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // busy has already dropped when done rises
    a_busy_low: assert property (@(posedge clk) disable iff (!rst) done |-> !busy)
        else $error("busy high while done is high");

    a_err_code: assert property (@(posedge clk) disable iff (!rst)
                                 res.num_of_errors != 2'd3)
        else $error("res.num_of_errors holds the unused code 3");

endmodule

bind ecc_ctrl_fsm ecc_asserts u_asserts (
    .clk  (clk),
    .rst  (rst),
    .busy (busy),
    .done (done),
    .res  (res)
);

`default_nettype wire

//--- ecc_codec.f
ecc_pkg.sv
ecc_encoder.sv
ecc_syndrome.sv
ecc_dec_chk.sv
ecc_err_stats.sv
ecc_ctrl_fsm.sv
ecc_codec.sv
ecc_asserts.sv
tb_ecc_codec.sv

//--- ecc_codec.sv
`default_nettype none
`timescale 1ns/1ns

module ecc_codec #(
    parameter int MAX_CODEWORD_WIDTH = 32,   // 16 drops the 26+6 mode
    parameter int MAX_INFO_WIDTH     = 26,
    parameter int STAT_WIDTH         = ecc_pkg::STAT_WIDTH_DEFAULT
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire ecc_pkg::ecc_req_t   req,
    input  wire logic                stats_clear,
    output logic                     busy,
    output logic                     done,
    output ecc_pkg::ecc_res_t        res,
    output ecc_pkg::ecc_stats_t      stats
);
    import ecc_pkg::*;

    localparam int PAR_W = MAX_CODEWORD_WIDTH - MAX_INFO_WIDTH;

    ecc_req_t                      req_q;
    logic                          enc_load;
    logic                          syn_load;
    logic                          syn_from_enc;
    logic                          chk_done;
    logic [31:0]                   codeword;
    logic [MAX_CODEWORD_WIDTH-1:0] rx_word;
    logic [MAX_CODEWORD_WIDTH-1:0] chk_data;
    logic [PAR_W-1:0]              s_vector;
    logic [1:0]                    chk_errors;

    ecc_ctrl_fsm #(
        .MAX_CODEWORD_WIDTH (MAX_CODEWORD_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .req          (req),
        .codeword     (codeword),
        .chk_data     (chk_data),
        .chk_errors   (chk_errors),
        .req_q        (req_q),
        .enc_load     (enc_load),
        .syn_load     (syn_load),
        .syn_from_enc (syn_from_enc),
        .chk_done     (chk_done),
        .busy         (busy),
        .done         (done),
        .res          (res)
    );

    ecc_encoder #(
        .MAX_CODEWORD_WIDTH (MAX_CODEWORD_WIDTH),
        .MAX_INFO_WIDTH     (MAX_INFO_WIDTH)
    ) u_encoder (
        .clk      (clk),
        .rst      (rst),
        .enc_load (enc_load),
        .mode     (req_q.mode),
        .info     (req_q.data),
        .codeword (codeword)
    );

    ecc_syndrome #(
        .MAX_CODEWORD_WIDTH (MAX_CODEWORD_WIDTH),
        .MAX_INFO_WIDTH     (MAX_INFO_WIDTH)
    ) u_syndrome (
        .clk          (clk),
        .rst          (rst),
        .syn_load     (syn_load),
        .syn_from_enc (syn_from_enc),
        .mode         (req_q.mode),
        .data         (req_q.data),
        .enc_word     (codeword),
        .noise        (req_q.noise),
        .rx_word      (rx_word),
        .s_vector     (s_vector)
    );

    ecc_dec_chk #(
        .MAX_CODEWORD_WIDTH (MAX_CODEWORD_WIDTH),
        .MAX_INFO_WIDTH     (MAX_INFO_WIDTH)
    ) u_dec_chk (
        .rst           (rst),
        .clk           (clk),
        .data_in       (rx_word),
        .s_vector      (s_vector),
        .work_mod      (req_q.mode),
        .data_out      (chk_data),
        .num_of_errors (chk_errors)
    );

    ecc_err_stats #(
        .STAT_WIDTH (STAT_WIDTH)
    ) u_err_stats (
        .clk           (clk),
        .rst           (rst),
        .chk_done      (chk_done),
        .num_of_errors (res.num_of_errors),   // held result of the finished request
        .stats_clear   (stats_clear),
        .stats         (stats)
    );

endmodule

`default_nettype wire

//--- ecc_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/1ns

module ecc_ctrl_fsm #(
    parameter int MAX_CODEWORD_WIDTH = 32
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,
    input  wire ecc_pkg::ecc_req_t             req,
    input  wire logic [31:0]                   codeword,
    input  wire logic [MAX_CODEWORD_WIDTH-1:0] chk_data,
    input  wire logic [1:0]                    chk_errors,
    output ecc_pkg::ecc_req_t                  req_q,
    output logic                               enc_load,
    output logic                               syn_load,
    output logic                               syn_from_enc,
    output logic                               chk_done,
    output logic                               busy,
    output logic                               done,
    output ecc_pkg::ecc_res_t                  res
);
    import ecc_pkg::*;

    typedef enum logic [2:0] {
        idle,
        encode,
        syndrome,
        check,
        finish
    } state_t;

    state_t      state;
    state_t      state_next;
    logic [31:0] chk_wide;

    assign chk_wide = 32'(chk_data);

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (start) begin
                    if (req.op == op_encode || req.op == op_channel) begin
                        state_next = encode;
                    end else begin
                        state_next = syndrome;   // decode, and any unknown op
                    end
                end
            end
            encode:   state_next = (req_q.op == op_channel) ? syndrome : finish;
            syndrome: state_next = check;
            check:    state_next = finish;         // checker registers during this cycle
            finish:   state_next = idle;
            default:  state_next = idle;
        endcase
    end

    assign enc_load     = (state == encode);
    assign syn_load     = (state == syndrome);
    assign syn_from_enc = (req_q.op == op_channel);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= idle;
            req_q    <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            chk_done <= 1'b0;
            res      <= '0;
        end else begin
            state    <= state_next;
            busy     <= (state_next != idle);      // drops on the edge done rises
            done     <= (state == finish);
            chk_done <= (state == finish) && (req_q.op != op_encode);
            if (state == idle && start) begin
                req_q <= req;                      // start while busy is ignored
            end
            if (state == finish) begin
                if (req_q.op == op_encode) begin
                    res.data          <= codeword;
                    res.num_of_errors <= 2'd0;
                end else begin
                    res.data          <= chk_wide;
                    res.num_of_errors <= chk_errors;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ecc_dec_chk.sv
`default_nettype none
`timescale 1ns/1ns

module ecc_dec_chk #(
    parameter int MAX_CODEWORD_WIDTH = 32,
    parameter int MAX_INFO_WIDTH     = 26
) (
    input  wire logic                                         rst,
    input  wire logic                                         clk,
    input  wire logic [MAX_CODEWORD_WIDTH-1:0]                data_in,
    input  wire logic [MAX_CODEWORD_WIDTH-MAX_INFO_WIDTH-1:0] s_vector,
    input  wire ecc_pkg::ecc_mode_t                           work_mod,
    output logic [MAX_CODEWORD_WIDTH-1:0]                     data_out,
    output logic [1:0]                                        num_of_errors
);
    import ecc_pkg::*;

    localparam int CW               = MAX_CODEWORD_WIDTH;
    localparam int MAX_PARITY_WIDTH = MAX_CODEWORD_WIDTH - MAX_INFO_WIDTH;

    logic [CW-1:0] corr_vec [NUM_MODES];
    logic [CW-1:0] flip;
    logic [CW-1:0] fixed_word;
    logic          eq_to_col;

    // one column of H, cut to the parity rows of this build
    function automatic logic [MAX_PARITY_WIDTH-1:0] h_column(input h_matrix_t h, input int c);
        logic [MAX_PARITY_WIDTH-1:0] col;
        for (int r = 0; r < MAX_PARITY_WIDTH; r++) begin
            col[r] = h[r][c];
        end
        return col;
    endfunction

    for (genvar g = 0; g < NUM_MODES; g++) begin : g_mode
        localparam int        L = code_len(g);
        localparam h_matrix_t H = h_matrix(g);

        if (mode_fits(g, CW) && PAR_LEN[g] <= MAX_PARITY_WIDTH) begin : g_on
            logic [CW-1:0] corr;

            always_comb begin
                corr = '0;                         // padding columns never match
                for (int c = 0; c < L; c++) begin
                    corr[c] = (h_column(H, c) == s_vector);
                end
            end

            assign corr_vec[g] = corr;
        end else begin : g_off
            assign corr_vec[g] = '0;
        end
    end

    always_comb begin
        case (work_mod)
            mode_8:  flip = corr_vec[0];
            mode_16: flip = corr_vec[1];
            mode_32: flip = corr_vec[2];
            default: flip = '0;
        endcase
    end

    assign eq_to_col  = |flip;                     // syndrome equals some column
    assign fixed_word = data_in ^ flip;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_out      <= '0;
            num_of_errors <= 2'd0;
        end else begin
            data_out <= fixed_word;
            if (s_vector == '0) begin
                num_of_errors <= 2'd0;
            end else if (eq_to_col) begin
                num_of_errors <= 2'd1;             // single error, corrected
            end else begin
                num_of_errors <= 2'd2;             // double error, left as is
            end
        end
    end

endmodule

`default_nettype wire

//--- ecc_encoder.sv
`default_nettype none
`timescale 1ns/1ns

module ecc_encoder #(
    parameter int MAX_CODEWORD_WIDTH = 32,
    parameter int MAX_INFO_WIDTH     = 26
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               enc_load,
    input  wire ecc_pkg::ecc_mode_t mode,
    input  wire logic [31:0]        info,
    output logic [31:0]             codeword
);
    import ecc_pkg::*;

    localparam int PAR_W = MAX_CODEWORD_WIDTH - MAX_INFO_WIDTH;

    logic [31:0] mode_word [NUM_MODES];
    logic [31:0] next_word;

    for (genvar g = 0; g < NUM_MODES; g++) begin : g_mode
        localparam int        P = PAR_LEN[g];
        localparam int        K = INFO_LEN[g];
        localparam h_matrix_t H = h_matrix(g);

        if (mode_fits(g, MAX_CODEWORD_WIDTH) && P <= PAR_W) begin : g_on
            logic [31:0] placed;
            logic [31:0] word;

            // parity sits in columns 0..P-1, info above it in ascending order
            always_comb begin
                placed = '0;
                placed[K+P-1:P] = info[K-1:0];
                word = placed;
                for (int r = 0; r < P - 1; r++) begin
                    word[r] = ^(H[r] & placed);   // column r is the only parity hit in row r
                end
                word[P-1] = ^(H[P-1] & word);     // overall parity over everything else
            end

            assign mode_word[g] = word;
        end else begin : g_off
            assign mode_word[g] = '0;             // mode not present in this build
        end
    end

    always_comb begin
        case (mode)
            mode_8:  next_word = mode_word[0];
            mode_16: next_word = mode_word[1];
            mode_32: next_word = mode_word[2];
            default: next_word = info;            // invalid mode passes through
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            codeword <= '0;
        end else if (enc_load) begin
            codeword <= next_word;
        end
    end

endmodule

`default_nettype wire

//--- ecc_err_stats.sv
`default_nettype none
`timescale 1ns/1ns

module ecc_err_stats #(
    parameter int STAT_WIDTH = 16
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         chk_done,
    input  wire logic [1:0]   num_of_errors,
    input  wire logic         stats_clear,
    output ecc_pkg::ecc_stats_t stats
);
    import ecc_pkg::*;

    if ($bits(ecc_stats_t) != 3 * STAT_WIDTH) begin : g_width_check
        $error("STAT_WIDTH does not match the counter fields of ecc_stats_t");
    end

    function automatic logic [STAT_WIDTH-1:0] sat_inc(input logic [STAT_WIDTH-1:0] v);
        return (&v) ? v : v + 1'b1;                // hold at all ones
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stats <= '0;
        end else if (stats_clear) begin
            stats <= '0;                           // clear beats a pending update
        end else if (chk_done) begin
            stats.decoded <= sat_inc(stats.decoded);
            if (num_of_errors == 2'd1) begin
                stats.corrected <= sat_inc(stats.corrected);
            end else if (num_of_errors == 2'd2) begin
                stats.uncorrectable <= sat_inc(stats.uncorrectable);
            end
        end
    end

endmodule

`default_nettype wire

//--- ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    localparam int NUM_MODES          = 3;
    localparam int H_ROWS             = 6;   // parity rows of the widest mode
    localparam int WORD_WIDTH         = 32;
    localparam int STAT_WIDTH_DEFAULT = 16;

    typedef enum logic [1:0] {
        mode_8  = 2'd0,
        mode_16 = 2'd1,
        mode_32 = 2'd2                       // 2'd3 is invalid
    } ecc_mode_t;

    typedef enum logic [1:0] {
        op_encode  = 2'd0,
        op_decode  = 2'd1,
        op_channel = 2'd2
    } ecc_op_t;

    typedef struct packed {
        ecc_op_t                 op;
        ecc_mode_t               mode;
        logic [WORD_WIDTH-1:0]   data;       // info bits or codeword
        logic [WORD_WIDTH-1:0]   noise;      // bits to flip
    } ecc_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0]   data;
        logic [1:0]              num_of_errors;
    } ecc_res_t;

    typedef struct packed {
        logic [STAT_WIDTH_DEFAULT-1:0] decoded;
        logic [STAT_WIDTH_DEFAULT-1:0] corrected;
        logic [STAT_WIDTH_DEFAULT-1:0] uncorrectable;
    } ecc_stats_t;

    localparam int INFO_LEN [NUM_MODES] = '{4, 11, 26};
    localparam int PAR_LEN  [NUM_MODES] = '{4, 5, 6};

    // row r of each matrix is one parity check, column c one codeword bit
    typedef logic [H_ROWS-1:0][WORD_WIDTH-1:0] h_matrix_t;

    localparam h_matrix_t H_MODE_1 = {32'h0000_0000, 32'h0000_0000, 32'h0000_00ff,
                                      32'h0000_00e4, 32'h0000_00d2, 32'h0000_00b1};
    localparam h_matrix_t H_MODE_2 = {32'h0000_0000, 32'h0000_ffff, 32'h0000_fe08,
                                      32'h0000_f1c4, 32'h0000_cda2, 32'h0000_ab61};
    localparam h_matrix_t H_MODE_3 = {32'hffff_ffff, 32'hfffe_0010, 32'hff01_fc08,
                                      32'hf0f1_e384, 32'hcccd_9b42, 32'haaab_56c1};

    function automatic int code_len(input int m);
        return INFO_LEN[m] + PAR_LEN[m];
    endfunction

    // a mode exists in a build only if its codeword fits
    function automatic bit mode_fits(input int m, input int cw_width);
        return code_len(m) <= cw_width;
    endfunction

    function automatic h_matrix_t h_matrix(input int m);
        case (m)
            0:       return H_MODE_1;
            1:       return H_MODE_2;
            default: return H_MODE_3;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- ecc_stim.txt
// op mode data noise exp_data exp_err, all hex, encodes are also swept bit by bit
// op 3 is a random block: mode info noise_mask clean_codeword request_count
0 0 0000000b 00000000 000000b1 0
0 0 00000005 00000000 00000055 0
0 0 0000000f 00000000 000000ff 0
0 1 00000001 00000000 00000033 0
0 1 000004d2 00000000 00009a44 0
0 1 000007ff 00000000 0000ffff 0
0 2 00000001 00000000 00000063 0
0 2 02000001 00000000 8000007c 0
0 2 03ffffff 00000000 ffffffff 0
0 3 12345678 00000000 12345678 0
1 0 000000b1 00000000 000000b1 0
1 1 00009a44 00000000 00009a44 0
1 2 8000007c 00000000 8000007c 0
1 1 00009a4c 00000000 00009a44 1
1 2 ffffffff 00400000 ffffffff 1
1 0 000000b1 00000003 000000b2 2
1 3 deadbeef 00000000 deadbeef 0
2 0 0000000b 00000000 000000b1 0
2 0 0000000b 00000010 000000b1 1
2 1 000004d2 00008000 00009a44 1
2 1 000004d2 00000500 00009f44 2
2 2 02000001 80000001 0000007d 2
2 2 03ffffff 00010000 ffffffff 1
2 3 0000abcd 00000100 0000aacd 0
3 0 0000000b 000000ff 000000b1 10
3 2 02000001 ffffffff 8000007c 20

//--- ecc_syndrome.sv
`default_nettype none
`timescale 1ns/1ns

module ecc_syndrome #(
    parameter int MAX_CODEWORD_WIDTH = 32,
    parameter int MAX_INFO_WIDTH     = 26
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic                                         syn_load,
    input  wire logic                                         syn_from_enc,
    input  wire ecc_pkg::ecc_mode_t                           mode,
    input  wire logic [31:0]                                  data,
    input  wire logic [31:0]                                  enc_word,
    input  wire logic [31:0]                                  noise,
    output logic [MAX_CODEWORD_WIDTH-1:0]                     rx_word,
    output logic [MAX_CODEWORD_WIDTH-MAX_INFO_WIDTH-1:0]      s_vector
);
    import ecc_pkg::*;

    localparam int CW    = MAX_CODEWORD_WIDTH;
    localparam int PAR_W = MAX_CODEWORD_WIDTH - MAX_INFO_WIDTH;

    logic [31:0]      src_word;
    logic [PAR_W-1:0] mode_syn [NUM_MODES];

    assign src_word = (syn_from_enc ? enc_word : data) ^ noise;   // channel noise applied here

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rx_word <= '0;
        end else if (syn_load) begin
            rx_word <= src_word[CW-1:0];
        end
    end

    for (genvar g = 0; g < NUM_MODES; g++) begin : g_mode
        localparam int        P = PAR_LEN[g];
        localparam h_matrix_t H = h_matrix(g);

        if (mode_fits(g, CW) && P <= PAR_W) begin : g_on
            logic [PAR_W-1:0] syn;

            always_comb begin
                syn = '0;                          // rows past the mode's parity stay zero
                for (int r = 0; r < P; r++) begin
                    syn[r] = ^(H[r][CW-1:0] & rx_word);
                end
            end

            assign mode_syn[g] = syn;
        end else begin : g_off
            assign mode_syn[g] = '0;
        end
    end

    always_comb begin
        case (mode)
            mode_8:  s_vector = mode_syn[0];
            mode_16: s_vector = mode_syn[1];
            mode_32: s_vector = mode_syn[2];
            default: s_vector = '0;                // invalid mode looks clean
        endcase
    end

endmodule

`default_nettype wire

//--- tb_ecc_codec.sv
`default_nettype none
`timescale 1ns/1ns

module tb_ecc_codec;
    import ecc_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DONE_LIMIT = 16;          // enough for the five cycles of a channel request

    logic        clk;
    logic        rst;
    logic        start;
    logic        stats_clear;
    ecc_req_t    req;
    logic        busy;
    logic        done;
    ecc_res_t    res;
    ecc_stats_t  stats;

    ecc_stats_t  exp_stats;
    logic [31:0] lfsr;
    int          res_errors;
    int          stats_errors;
    int          proto_errors;
    int          done_count;
    int          accepted;

    ecc_codec UUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .req         (req),
        .stats_clear (stats_clear),
        .busy        (busy),
        .done        (done),
        .res         (res),
        .stats       (stats)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst && done) begin
            done_count++;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic int code_bits(input logic [1:0] mode);
        case (mode)
            2'd0:    return 8;
            2'd1:    return 16;
            2'd2:    return 32;
            default: return 0;
        endcase
    endfunction

    task automatic check_res(input ecc_res_t got, input ecc_res_t want, input string tag);
        if (got.data !== want.data) begin
            $display("error: res.data got %h expected %h, %s", got.data, want.data, tag);
            res_errors++;
        end
        if (got.num_of_errors !== want.num_of_errors) begin
            $display("error: res.num_of_errors got %h expected %h, %s",
                     got.num_of_errors, want.num_of_errors, tag);
            res_errors++;
        end
    endtask

    task automatic check_stats(input ecc_stats_t got, input ecc_stats_t want);
        if (got.decoded !== want.decoded) begin
            $display("error: stats.decoded got %h expected %h", got.decoded, want.decoded);
            stats_errors++;
        end
        if (got.corrected !== want.corrected) begin
            $display("error: stats.corrected got %h expected %h", got.corrected, want.corrected);
            stats_errors++;
        end
        if (got.uncorrectable !== want.uncorrectable) begin
            $display("error: stats.uncorrectable got %h expected %h",
                     got.uncorrectable, want.uncorrectable);
            stats_errors++;
        end
    endtask

    // only decode and channel outcomes reach the counters
    task automatic tally(input ecc_op_t op, input logic [1:0] err);
        if (op != op_encode) begin
            exp_stats.decoded++;
            if (err == 2'd1) exp_stats.corrected++;
            if (err == 2'd2) exp_stats.uncorrectable++;
        end
    endtask

    task automatic send_request(input ecc_req_t r);
        @(negedge clk);
        req   = r;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        accepted++;
    endtask

    task automatic wait_done(output bit ok);
        int n;
        n = 0;
        while (!done && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = done;
        if (!ok) begin
            $display("no done within limit");
            proto_errors++;
        end
    endtask

    task automatic run_request(input logic [31:0] op, input logic [31:0] mode,
                               input logic [31:0] data, input logic [31:0] noise,
                               input logic [31:0] want_data, input logic [1:0] want_err,
                               input string tag);
        ecc_req_t r;
        ecc_res_t want;
        bit       ok;
        r.op               = ecc_op_t'(op[1:0]);
        r.mode             = ecc_mode_t'(mode[1:0]);
        r.data             = data;
        r.noise            = noise;
        want.data          = want_data;
        want.num_of_errors = want_err;
        send_request(r);
        wait_done(ok);
        if (ok) check_res(res, want, tag);
        tally(r.op, want_err);
    endtask

    // every single-bit error of a clean codeword must be repaired
    task automatic sweep_flips(input logic [31:0] mode, input logic [31:0] codeword);
        for (int i = 0; i < code_bits(mode[1:0]); i++) begin
            run_request(32'd1, mode, codeword ^ (32'd1 << i), 32'd0, codeword, 2'd1,
                        $sformatf("flip bit %0d", i));
        end
    endtask

    task automatic random_block(input logic [31:0] mode, input logic [31:0] info,
                                input logic [31:0] mask, input logic [31:0] codeword,
                                input logic [31:0] count);
        logic [31:0] sel;
        logic [31:0] pos;
        logic [31:0] noise;
        int          len;
        int          weight;
        len = $countones(mask);
        for (int k = 0; k < int'(count); k++) begin
            draw_bits(2, sel);
            noise = '0;
            for (int f = 0; f < int'(sel % 3); f++) begin
                draw_bits(5, pos);
                noise |= 32'd1 << (pos % len);
            end
            noise &= mask;
            weight = $countones(noise);
            if (weight < 2) begin
                run_request(32'd2, mode, info, noise, codeword, 2'(weight), "random");
            end else begin
                run_request(32'd2, mode, info, noise, codeword ^ noise, 2'd2, "random");
            end
        end
    endtask

    // a second start while busy must not produce a second result
    task automatic busy_drop_check();
        ecc_req_t first;
        ecc_req_t second;
        ecc_res_t want;
        bit       ok;
        first              = '{op: op_decode, mode: mode_16, data: 32'h0000_9844, noise: '0};
        second             = '{op: op_encode, mode: mode_8, data: 32'h0000_000f, noise: '0};
        want.data          = 32'h0000_9a44;
        want.num_of_errors = 2'd1;
        @(negedge clk);
        req   = first;
        start = 1'b1;
        @(negedge clk);
        req = second;
        if (busy !== 1'b1) begin
            $display("error: busy got %h expected %h after an accepted start", busy, 1'b1);
            proto_errors++;
        end
        @(negedge clk);
        start = 1'b0;
        accepted++;
        wait_done(ok);
        if (ok) check_res(res, want, "start while busy");
        tally(op_decode, 2'd1);
        repeat (8) @(negedge clk);           // room for a stray second done
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] op_v;
        logic [31:0] mode_v;
        logic [31:0] data_v;
        logic [31:0] noise_v;
        logic [31:0] want_v;
        logic [31:0] cnt_v;
        rst          = 1'b0;
        start        = 1'b0;
        stats_clear  = 1'b0;
        req          = '0;
        lfsr         = 32'hba8f;
        exp_stats    = '0;
        res_errors   = 0;
        stats_errors = 0;
        proto_errors = 0;
        done_count   = 0;
        accepted     = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        if (busy !== 1'b0) begin
            $display("error: busy got %h expected %h after reset", busy, 1'b0);
            proto_errors++;
        end
        if (done !== 1'b0) begin
            $display("error: done got %h expected %h after reset", done, 1'b0);
            proto_errors++;
        end
        check_res(res, '0, "after reset");
        check_stats(stats, '0);

        fd = $fopen("ecc_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file ecc_stim.txt");
            proto_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                op_v, mode_v, data_v, noise_v, want_v, cnt_v);
                    if (n != 6) begin
                        $display("malformed stimulus line: %s", line);
                        proto_errors++;
                    end else if (op_v == 32'd3) begin
                        random_block(mode_v, data_v, noise_v, want_v, cnt_v);
                    end else begin
                        run_request(op_v, mode_v, data_v, noise_v, want_v, cnt_v[1:0], line);
                        if (op_v == 32'd0 && mode_v < 32'd3) sweep_flips(mode_v, want_v);
                    end
                end
            end
            $fclose(fd);
        end

        busy_drop_check();
        @(negedge clk);                      // counters move on the edge after done
        check_stats(stats, exp_stats);
        stats_clear = 1'b1;
        @(negedge clk);
        stats_clear = 1'b0;
        check_stats(stats, '0);
        if (done_count != accepted) begin
            $display("error: done pulses got %h expected %h", done_count, accepted);
            proto_errors++;
        end

        $display("errors: res %0d stats %0d protocol %0d", res_errors, stats_errors,
                 proto_errors);
        if (res_errors + stats_errors + proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
